/* common/ac97_pkg.sv */
package ac97_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and buttons
  ////////////////////////////////////////////////////////////////////////////

  localparam int BTN_UP      = 0;
  localparam int BTN_DOWN    = 1;
  localparam int NUM_BUTTONS = 2;

  typedef logic [4:0]             volume_t;
  typedef logic [7:0]             sample_t;
  typedef logic [19:0]            slot_t;
  typedef logic [7:0]             cmd_addr_t;
  typedef logic [15:0]            cmd_data_t;
  typedef logic [7:0]             bit_count_t;
  typedef logic [NUM_BUTTONS-1:0] button_vec_t;

  // one codec register access, 25 bits
  typedef struct packed {
    logic      valid;
    cmd_addr_t addr;
    cmd_data_t data;
  } ac97_cmd_t;

  // 16 steps, wraps from the last idle back to the first id read
  typedef enum logic [3:0] {
    STEP_READ_ID0, STEP_READ_ID1, STEP_IDLE2,     STEP_HP_VOL,
    STEP_IDLE4,    STEP_PCM_VOL,  STEP_REC_SEL,   STEP_REC_GAIN,
    STEP_IDLE8,    STEP_MIC_GAIN, STEP_BEEP_VOL,  STEP_GP_BYPASS,
    STEP_IDLE12,   STEP_IDLE13,   STEP_IDLE14,    STEP_IDLE15
  } cmd_step_t;

  localparam volume_t VOLUME_RESET = 5'd8;
  localparam volume_t VOLUME_MAX   = 5'd31;

  ////////////////////////////////////////////////////////////////////////////
  // frame layout, positions within the 256-bit frame
  ////////////////////////////////////////////////////////////////////////////

  localparam bit_count_t FRAME_LAST       = 8'd255;
  localparam bit_count_t SYNC_LAST        = 8'd15;
  localparam bit_count_t FRAME_STROBE_POS = 8'd128;
  localparam bit_count_t SLOT_CMD_ADDR    = 8'd16;
  localparam bit_count_t SLOT_CMD_DATA    = 8'd36;
  localparam bit_count_t SLOT_LEFT        = 8'd56;
  localparam bit_count_t SLOT_RIGHT       = 8'd76;
  localparam bit_count_t SLOT_END         = 8'd96;
  // codec input lags the output slot by one bit
  localparam bit_count_t RX_LEFT_FIRST    = 8'd57;
  localparam int         SLOT_BITS        = 20;

  // codec register map
  localparam cmd_addr_t REG_READ_ID  = 8'h80;
  localparam cmd_addr_t REG_HP_VOL   = 8'h04;
  localparam cmd_addr_t REG_PCM_VOL  = 8'h18;
  localparam cmd_addr_t REG_REC_SEL  = 8'h1A;
  localparam cmd_addr_t REG_REC_GAIN = 8'h1C;
  localparam cmd_addr_t REG_MIC_GAIN = 8'h0E;
  localparam cmd_addr_t REG_BEEP_VOL = 8'h0A;
  localparam cmd_addr_t REG_GP       = 8'h20;

  localparam cmd_data_t PCM_VOL_DATA   = 16'h0808;
  // record gain at max
  localparam cmd_data_t REC_GAIN_DATA  = 16'h0F0F;
  // +20 dB mic boost
  localparam cmd_data_t MIC_GAIN_DATA  = 16'h8048;
  localparam cmd_data_t BEEP_VOL_DATA  = 16'h0000;
  // pcm out bypasses the 3d mixer
  localparam cmd_data_t GP_BYPASS_DATA = 16'h8000;

  localparam logic [2:0] REC_SOURCE_MIC = 3'd0;

endpackage

/* verilog/debounce.sv */
`timescale 1ns/10ps

module debounce #(
  parameter int debounce_cycles = 270000
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int COUNT_W = $clog2(debounce_cycles + 1);

  typedef logic [COUNT_W-1:0] count_t;

  localparam count_t COUNT_LAST = count_t'(debounce_cycles);

  count_t count;
  // last level seen on the pin
  logic   held;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      held  <= noisy;
      clean <= noisy;
    end else if (noisy != held) begin
      // input moved, restart the stable interval
      held  <= noisy;
      count <= '0;
    end else if (count == COUNT_LAST) begin
      clean <= held;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* verilog/volume_control.sv */
`timescale 1ns/10ps

module volume_control
  import ac97_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  button_vec_t clean_buttons,
  output volume_t     volume
);

  // clean levels one cycle back
  button_vec_t prev_buttons;
  button_vec_t rise;

  assign rise = clean_buttons & ~prev_buttons;

  always_ff @(posedge clock) begin
    if (reset) begin
      prev_buttons <= '0;
      volume       <= VOLUME_RESET;
    end else begin
      prev_buttons <= clean_buttons;
      // down edge has priority over up
      if (rise[BTN_DOWN]) begin
        // saturate at silence
        if (volume != '0) begin
          volume <= volume - 1'b1;
        end
      end else if (rise[BTN_UP]) begin
        // saturate at full scale
        if (volume != VOLUME_MAX) begin
          volume <= volume + 1'b1;
        end
      end
    end
  end

endmodule

/* ac97/ac97_command_seq.sv */
`timescale 1ns/10ps

module ac97_command_seq
  import ac97_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      frame_strobe,
  input  volume_t   volume,
  output ac97_cmd_t command
);

  cmd_step_t step;
  cmd_step_t step_next;
  // codec wants attenuation, not gain
  volume_t   atten;

  assign atten     = VOLUME_MAX - volume;
  // 4-bit add wraps IDLE15 back to READ_ID0
  assign step_next = cmd_step_t'(step + 1'b1);

  function automatic ac97_cmd_t step_command(cmd_step_t s, volume_t att);
    ac97_cmd_t cmd;
    // idle steps fall back to a harmless id read
    cmd.valid = 1'b1;
    cmd.addr  = REG_READ_ID;
    cmd.data  = '0;
    case (s)
      STEP_HP_VOL: begin
        cmd.addr = REG_HP_VOL;
        cmd.data = {3'b000, att, 3'b000, att};
      end
      STEP_PCM_VOL: begin
        cmd.addr = REG_PCM_VOL;
        cmd.data = PCM_VOL_DATA;
      end
      STEP_REC_SEL: begin
        // same source on both channels
        cmd.addr = REG_REC_SEL;
        cmd.data = {5'b00000, REC_SOURCE_MIC, 5'b00000, REC_SOURCE_MIC};
      end
      STEP_REC_GAIN: begin
        cmd.addr = REG_REC_GAIN;
        cmd.data = REC_GAIN_DATA;
      end
      STEP_MIC_GAIN: begin
        cmd.addr = REG_MIC_GAIN;
        cmd.data = MIC_GAIN_DATA;
      end
      STEP_BEEP_VOL: begin
        cmd.addr = REG_BEEP_VOL;
        cmd.data = BEEP_VOL_DATA;
      end
      STEP_GP_BYPASS: begin
        cmd.addr = REG_GP;
        cmd.data = GP_BYPASS_DATA;
      end
      default: begin
      end
    endcase
    return cmd;
  endfunction

  // command tracks volume every cycle, and the new step right after the strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      step    <= STEP_READ_ID0;
      command <= '0;
    end else begin
      if (frame_strobe) begin
        step <= step_next;
      end
      command <= step_command(frame_strobe ? step_next : step, atten);
    end
  end

endmodule

/* ac97/ac97_frame.sv */
`timescale 1ns/10ps

module ac97_frame
  import ac97_pkg::*;
#(
  parameter int reset_hold_cycles = 1024
) (
  input  logic      clock,
  input  logic      reset,
  input  ac97_cmd_t command,
  input  sample_t   audio_out_data,
  output logic      frame_strobe,
  output sample_t   audio_in_data,
  output logic      audio_reset_b,
  output logic      ac97_sync,
  output logic      ac97_sdata_out,
  input  logic      ac97_sdata_in
);

  localparam int HOLD_W = (reset_hold_cycles > 1) ? $clog2(reset_hold_cycles) : 1;

  typedef logic [HOLD_W-1:0] hold_count_t;

  localparam hold_count_t HOLD_LAST = hold_count_t'(reset_hold_cycles - 1);
  // bit_count runs one ahead of the pins, so rx edges shift by one
  localparam bit_count_t RX_SHIFT_FIRST = bit_count_t'(RX_LEFT_FIRST + 1);
  localparam bit_count_t RX_SHIFT_LAST  = bit_count_t'(RX_LEFT_FIRST + SLOT_BITS);

  hold_count_t hold_count;
  // position driven on the pins next cycle
  bit_count_t  bit_count;
  logic        l_cmd_valid;
  logic        l_pcm_valid;
  slot_t       l_cmd_addr;
  slot_t       l_cmd_data;
  // one word feeds both pcm slots
  slot_t       l_pcm;
  slot_t       rx_shift;
  logic        tx_bit;

  // msb-first bit of a slot word at frame position pos
  function automatic logic slot_bit(slot_t word, bit_count_t pos, bit_count_t start);
    bit_count_t offset;
    offset = pos - start;
    return word[SLOT_BITS - 1 - int'(offset)];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // codec reset hold
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_count    <= '0;
      audio_reset_b <= 1'b0;
    end else if (!audio_reset_b) begin
      if (hold_count == HOLD_LAST) begin
        audio_reset_b <= 1'b1;
      end else begin
        hold_count <= hold_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame serializer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    tx_bit = 1'b0;
    if (bit_count <= SYNC_LAST) begin
      // slot 0 tags
      case (bit_count[3:0])
        4'd0:       tx_bit = 1'b1;
        4'd1, 4'd2: tx_bit = l_cmd_valid;
        4'd3, 4'd4: tx_bit = l_pcm_valid;
        default:    tx_bit = 1'b0;
      endcase
    end else if (bit_count < SLOT_CMD_DATA) begin
      tx_bit = l_cmd_valid & slot_bit(l_cmd_addr, bit_count, SLOT_CMD_ADDR);
    end else if (bit_count < SLOT_LEFT) begin
      tx_bit = l_cmd_valid & slot_bit(l_cmd_data, bit_count, SLOT_CMD_DATA);
    end else if (bit_count < SLOT_RIGHT) begin
      tx_bit = l_pcm_valid & slot_bit(l_pcm, bit_count, SLOT_LEFT);
    end else if (bit_count < SLOT_END) begin
      tx_bit = l_pcm_valid & slot_bit(l_pcm, bit_count, SLOT_RIGHT);
    end
  end

  // counter held at 0 until the codec leaves reset
  always_ff @(posedge clock) begin
    if (reset || !audio_reset_b) begin
      bit_count      <= '0;
      ac97_sync      <= 1'b0;
      ac97_sdata_out <= 1'b0;
      frame_strobe   <= 1'b0;
      l_cmd_valid    <= 1'b0;
      l_pcm_valid    <= 1'b0;
    end else begin
      bit_count      <= bit_count + 1'b1;
      ac97_sync      <= (bit_count <= SYNC_LAST);
      frame_strobe   <= (bit_count == FRAME_STROBE_POS);
      ac97_sdata_out <= tx_bit;
      // tags for the next frame
      if (bit_count == FRAME_LAST) begin
        l_cmd_valid <= command.valid;
        l_pcm_valid <= 1'b1;
      end
    end
  end

  // slot words for the next frame, left justified
  always_ff @(posedge clock) begin
    if (bit_count == FRAME_LAST) begin
      l_cmd_addr <= {command.addr, 12'h000};
      l_cmd_data <= {command.data, 4'h0};
      l_pcm      <= {audio_out_data, 12'h000};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // left input slot capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (bit_count >= RX_SHIFT_FIRST && bit_count <= RX_SHIFT_LAST) begin
      rx_shift <= {rx_shift[SLOT_BITS-2:0], ac97_sdata_in};
    end
  end

  // last bit lands this edge, so take the top byte from the shifted view
  always_ff @(posedge clock) begin
    if (reset) begin
      audio_in_data <= '0;
    end else if (bit_count == RX_SHIFT_LAST) begin
      audio_in_data <= rx_shift[SLOT_BITS-2 -: $bits(sample_t)];
    end
  end

endmodule

/* verilog/ac97_voice_top.sv */
`timescale 1ns/10ps

module ac97_voice_top
  import ac97_pkg::*;
#(
  parameter int debounce_cycles   = 270000,
  parameter int reset_hold_cycles = 1024
) (
  input  logic        clock,
  input  logic        reset,
  input  button_vec_t buttons,
  input  sample_t     audio_out_data,
  output sample_t     audio_in_data,
  output volume_t     volume,
  output logic        audio_reset_b,
  output logic        ac97_sync,
  output logic        ac97_sdata_out,
  input  logic        ac97_sdata_in
);

  button_vec_t clean_buttons;
  logic        frame_strobe;
  ac97_cmd_t   command;

  // one filter per push button
  for (genvar i = 0; i < NUM_BUTTONS; i++) begin : g_debounce
    debounce #(
      .debounce_cycles(debounce_cycles)
    ) debounce0 (
      .clock(clock),
      .reset(reset),
      .noisy(buttons[i]),
      .clean(clean_buttons[i])
    );
  end

  volume_control volume_control0 (
    .clock(clock),
    .reset(reset),
    .clean_buttons(clean_buttons),
    .volume(volume)
  );

  // register writes, one per frame strobe
  ac97_command_seq ac97_command_seq0 (
    .clock(clock),
    .reset(reset),
    .frame_strobe(frame_strobe),
    .volume(volume),
    .command(command)
  );

  ac97_frame #(
    .reset_hold_cycles(reset_hold_cycles)
  ) ac97_frame0 (
    .clock(clock),
    .reset(reset),
    .command(command),
    .audio_out_data(audio_out_data),
    .frame_strobe(frame_strobe),
    .audio_in_data(audio_in_data),
    .audio_reset_b(audio_reset_b),
    .ac97_sync(ac97_sync),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

endmodule

/* tb/ac97_voice_chk.sv */
`timescale 1ns/10ps

module ac97_voice_chk
  import ac97_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input logic       audio_reset_b,
  input logic       ac97_sync,
  input logic       ac97_sdata_out,
  input logic       frame_strobe,
  input bit_count_t bit_count
);

  // length of the current sync pulse
  logic [8:0] sync_run;
  // cycles since the last strobe
  logic [8:0] since_strobe;
  logic       strobe_seen;
  // failed assertion count, read by the testbench
  int         fail_count = 0;

  always_ff @(posedge clock) begin
    if (reset) begin
      sync_run     <= '0;
      since_strobe <= '0;
      strobe_seen  <= 1'b0;
    end else begin
      sync_run     <= ac97_sync ? sync_run + 1'b1 : '0;
      since_strobe <= frame_strobe ? '0 : since_strobe + 1'b1;
      if (frame_strobe) begin
        strobe_seen <= 1'b1;
      end
    end
  end

  sync_length: assert property (@(posedge clock) disable iff (reset)
    $fell(ac97_sync) |-> sync_run == 9'd16)
    else begin
      fail_count++;
      $error("ac97_sync pulse not 16 cycles long");
    end

  sync_bound: assert property (@(posedge clock) disable iff (reset)
    ac97_sync |-> sync_run < 9'd16)
    else begin
      fail_count++;
      $error("ac97_sync high past the tag slot");
    end

  // bit_count runs one ahead, so pins show positions 96 to 255 here
  quiet_tail: assert property (@(posedge clock) disable iff (reset)
    (audio_reset_b && (bit_count > 8'd96 || bit_count == 8'd0)) |-> !ac97_sdata_out)
    else begin
      fail_count++;
      $error("ac97_sdata_out active after slot 4");
    end

  strobe_period: assert property (@(posedge clock) disable iff (reset)
    (frame_strobe && strobe_seen) |-> since_strobe == 9'd255)
    else begin
      fail_count++;
      $error("frame_strobe period not 256 cycles");
    end

  strobe_missing: assert property (@(posedge clock) disable iff (reset)
    strobe_seen |-> since_strobe < 9'd256)
    else begin
      fail_count++;
      $error("frame_strobe missing");
    end

endmodule

bind ac97_frame ac97_voice_chk chk0 (
  .clock(clock),
  .reset(reset),
  .audio_reset_b(audio_reset_b),
  .ac97_sync(ac97_sync),
  .ac97_sdata_out(ac97_sdata_out),
  .frame_strobe(frame_strobe),
  .bit_count(bit_count)
);

/* tb/tb_ac97_voice.sv */
`timescale 1ns/10ps

module tb_ac97_voice
  import ac97_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int DEBOUNCE     = 16;
  localparam int RESET_HOLD   = 20;
  localparam int RUN_FRAMES   = 40;
  localparam int LIMIT_FRAMES = 60;

  // one frame as seen on the codec side
  typedef struct packed {
    logic [15:0] tag;
    slot_t       addr;
    slot_t       data;
    slot_t       left;
    slot_t       right;
  } frame_fields_t;

  logic        clock = 1'b0;
  logic        reset;
  button_vec_t buttons;
  sample_t     audio_out_data;
  sample_t     audio_in_data;
  volume_t     volume;
  logic        audio_reset_b;
  logic        ac97_sync;
  logic        ac97_sdata_out;
  logic        ac97_sdata_in;

  int            value_errors = 0;
  int            other_errors = 0;
  int            assert_errors = 0;
  int            cycle_count = 0;
  int            last_rise = 0;
  // pin position of the current cycle, updated on the falling edge
  int            frame_pos = 0;
  int            frames_done = 0;
  bit            framing = 1'b0;
  bit            prev_sync = 1'b0;
  bit            hold_done = 1'b0;
  bit            rx_sent = 1'b0;
  bit            seq_locked = 1'b0;
  volume_t       model_volume = VOLUME_RESET;
  volume_t       pend_volume = VOLUME_RESET;
  volume_t       frame_volume = VOLUME_RESET;
  sample_t       pend_sample = '0;
  sample_t       frame_sample = '0;
  sample_t       rx_byte = '0;
  slot_t         rx_word = '0;
  frame_fields_t cur;
  frame_fields_t got_q[$];
  volume_t       vol_q[$];
  sample_t       smp_q[$];
  event          frame_done;

  ac97_voice_top #(
    .debounce_cycles(DEBOUNCE),
    .reset_hold_cycles(RESET_HOLD)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .buttons(buttons),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .volume(volume),
    .audio_reset_b(audio_reset_b),
    .ac97_sync(ac97_sync),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    assert (actual === expected) else begin
      value_errors++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(string what);
    other_errors++;
    $display("[ERROR] %0t %s", $time, what);
  endtask

  // expected frame for a sequencer step, from the codec register table
  function automatic frame_fields_t reference_frame(int step, volume_t vol, sample_t smp,
                                                    bit first);
    frame_fields_t f;
    cmd_addr_t     a;
    cmd_data_t     d;
    volume_t       att;
    att = 5'd31 - vol;
    a   = REG_READ_ID;
    d   = 16'h0000;
    case (step)
      3: begin
        a = REG_HP_VOL;
        d = {3'b000, att, 3'b000, att};
      end
      5: begin
        a = REG_PCM_VOL;
        d = PCM_VOL_DATA;
      end
      6: begin
        a = REG_REC_SEL;
        d = {5'b00000, REC_SOURCE_MIC, 5'b00000, REC_SOURCE_MIC};
      end
      7: begin
        a = REG_REC_GAIN;
        d = REC_GAIN_DATA;
      end
      9: begin
        a = REG_MIC_GAIN;
        d = MIC_GAIN_DATA;
      end
      10: begin
        a = REG_BEEP_VOL;
        d = BEEP_VOL_DATA;
      end
      11: begin
        a = REG_GP;
        d = GP_BYPASS_DATA;
      end
      default: begin
      end
    endcase
    // first frame only carries the frame-valid tag
    f.tag   = first ? 16'h8000 : 16'hF800;
    f.addr  = first ? '0 : {a, 12'h000};
    f.data  = first ? '0 : {d, 4'h0};
    f.left  = first ? '0 : {smp, 12'h000};
    f.right = f.left;
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // codec side, frame decoder
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (!reset) begin
      cycle_count++;
      if (!audio_reset_b) begin
        check_value("ac97_sync", ac97_sync, 1'b0);
        check_value("ac97_sdata_out", ac97_sdata_out, 1'b0);
      end else if (!hold_done) begin
        hold_done = 1'b1;
        // count starts half a cycle after reset drops
        check_value("audio_reset_b hold", cycle_count, RESET_HOLD + 1);
      end
      if (ac97_sync && !prev_sync) begin
        if (framing) begin
          check_value("ac97_sync period", cycle_count - last_rise, 256);
        end else begin
          check_value("ac97_sync first rise", cycle_count, RESET_HOLD + 2);
        end
        // byte sent in the previous frame
        if (rx_sent) begin
          check_value("audio_in_data", audio_in_data, rx_byte);
        end
        framing      = 1'b1;
        frame_pos    = 0;
        last_rise    = cycle_count;
        frame_volume = pend_volume;
        frame_sample = pend_sample;
      end else if (framing) begin
        frame_pos++;
      end
      prev_sync = ac97_sync;
      if (framing) begin
        if (frame_pos < 16) begin
          cur.tag = {cur.tag[14:0], ac97_sdata_out};
        end else if (frame_pos < 36) begin
          cur.addr = {cur.addr[18:0], ac97_sdata_out};
        end else if (frame_pos < 56) begin
          cur.data = {cur.data[18:0], ac97_sdata_out};
        end else if (frame_pos < 76) begin
          cur.left = {cur.left[18:0], ac97_sdata_out};
        end else if (frame_pos < 96) begin
          cur.right = {cur.right[18:0], ac97_sdata_out};
        end
        // inputs seen by the latch at the end of this frame
        if (frame_pos == 254) begin
          pend_volume = model_volume;
          pend_sample = audio_out_data;
        end
        if (frame_pos == 255) begin
          got_q.push_back(cur);
          vol_q.push_back(frame_volume);
          smp_q.push_back(frame_sample);
          -> frame_done;
        end
        if (frame_pos == 300) begin
          report_failure("ac97_sync stopped rising");
        end
      end
    end
  end

  // left input slot and output samples, driven just after the edge
  always @(posedge clock) begin : codec_drive
    int next_pos;
    #1;
    if (framing) begin
      next_pos = (frame_pos + 1) % 256;
      if (next_pos == 40) begin
        rx_byte = sample_t'($urandom);
        rx_word = {rx_byte, 12'($urandom)};
      end
      if (next_pos >= RX_LEFT_FIRST && next_pos < RX_LEFT_FIRST + SLOT_BITS) begin
        ac97_sdata_in = rx_word[SLOT_BITS - 1 - (next_pos - RX_LEFT_FIRST)];
        rx_sent       = 1'b1;
      end else begin
        ac97_sdata_in = 1'b0;
      end
      if (next_pos == 100) begin
        audio_out_data = sample_t'($urandom);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // comparison against the reference
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare
    frame_fields_t got;
    frame_fields_t exp;
    volume_t       vol;
    sample_t       smp;
    int            step;
    step = 0;
    forever begin
      @(frame_done);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        vol = vol_q.pop_front();
        smp = smp_q.pop_front();
        // lock the step index on the first headphone write
        if (frames_done > 0 && !seq_locked && got.addr == {REG_HP_VOL, 12'h000}) begin
          seq_locked = 1'b1;
          step       = 3;
        end
        exp = reference_frame(seq_locked ? step : 0, vol, smp, frames_done == 0);
        check_value("tag slot", got.tag, exp.tag);
        check_value("command address slot", got.addr, exp.addr);
        check_value("command data slot", got.data, exp.data);
        check_value("pcm left slot", got.left, exp.left);
        check_value("pcm right slot", got.right, exp.right);
        if (seq_locked) begin
          step = (step + 1) % 16;
        end
        frames_done++;
      end
    end
  end

  // random bounce, each burst shorter than the debounce interval
  task automatic bounce_button(int idx, logic level);
    int toggles;
    toggles = 2 + $urandom % 5;
    repeat (toggles) begin
      @(posedge clock);
      #1;
      buttons[idx] = ~buttons[idx];
      repeat ($urandom % 3) @(posedge clock);
    end
    @(posedge clock);
    #1;
    buttons[idx] = level;
  endtask

  task automatic press_button(int idx);
    int waited;
    // stay clear of the end-of-frame latch
    @(posedge clock);
    while (!framing || frame_pos > 170) @(posedge clock);
    #1;
    if (idx == BTN_UP && model_volume != VOLUME_MAX) begin
      model_volume++;
    end
    if (idx == BTN_DOWN && model_volume != 0) begin
      model_volume--;
    end
    bounce_button(idx, 1'b1);
    repeat (DEBOUNCE + 4) @(negedge clock);
    waited = 0;
    while (volume !== model_volume && waited < 8) begin
      @(negedge clock);
      waited++;
    end
    check_value("volume", volume, model_volume);
    bounce_button(idx, 1'b0);
    repeat (DEBOUNCE + 8) @(negedge clock);
    // release must leave volume alone
    check_value("volume after release", volume, model_volume);
  endtask

  initial begin : stimulus
    void'($urandom(64002));
    reset          = 1'b1;
    buttons        = '0;
    audio_out_data = '0;
    ac97_sdata_in  = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    wait (framing);
    check_value("volume", volume, VOLUME_RESET);
    repeat (3) press_button(BTN_UP);
    repeat (2) press_button(BTN_DOWN);
    // up to 31, then two presses into saturation
    repeat (24) press_button(BTN_UP);
    // down to 0, then two presses into saturation
    repeat (33) press_button(BTN_DOWN);
    while (frames_done < RUN_FRAMES) @(negedge clock);
    if (!seq_locked) begin
      report_failure("command sequence never reached the headphone volume step");
    end
    assert_errors = dut0.ac97_frame0.chk0.fail_count;
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errors, other_errors, assert_errors);
    if (value_errors + other_errors + assert_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // limit is the longest run plus the codec reset hold
  initial begin : watchdog
    #((LIMIT_FRAMES * 256 + RESET_HOLD + 10) * CLK_PERIOD);
    $display("[ERROR] %0t run did not finish in time, %0d frames checked", $time, frames_done);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* ac97_voice.f */
common/ac97_pkg.sv
verilog/debounce.sv
verilog/volume_control.sv
ac97/ac97_command_seq.sv
ac97/ac97_frame.sv
verilog/ac97_voice_top.sv
tb/ac97_voice_chk.sv
tb/tb_ac97_voice.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_ac97_voice
RTL_TOP    = ac97_voice_top
FILELIST   = ac97_voice.f
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall
OBJ_DIR    = obj_dir
PASS_MSG   = TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
